//--- include/imu_link_macros.svh
`ifndef IMU_LINK_MACROS_SVH
`define IMU_LINK_MACROS_SVH

// First byte of every frame, lets the MCU find frame alignment
`define IMU_HEADER 8'hAA

// Header + 8 quat bytes + 6 gyro bytes + flags byte
`define IMU_FRAME_BITS 128

// Flip-flops per line in the sck/load synchronizer
`define IMU_SYNC_STAGES 2

`endif

//--- design/imu_link_pkg.sv
package imu_link_pkg;

    // Raw quaternion from the sensor controller, w goes out first
    typedef struct packed {
        logic signed [15:0] w;
        logic signed [15:0] x;
        logic signed [15:0] y;
        logic signed [15:0] z;
    } imu_quat_t;

    // Three-axis vector, used for the gyroscope
    typedef struct packed {
        logic signed [15:0] x;
        logic signed [15:0] y;
        logic signed [15:0] z;
    } imu_vec_t;

    // Last byte of the frame: bit 1 gyro, bit 0 quat
    typedef struct packed {
        logic [5:0] reserved;                   // Always sent as zero
        logic       gyro_valid;
        logic       quat_valid;
    } imu_flags_t;

    typedef struct packed {
        imu_quat_t  quat;
        imu_vec_t   gyro;
        imu_flags_t flags;
    } imu_sample_t;

    // Field order is wire order, MSB of header leaves first
    typedef struct packed {
        logic [7:0] header;
        imu_quat_t  quat;
        imu_vec_t   gyro;
        imu_flags_t flags;
    } imu_frame_t;

    typedef enum logic [1:0] {
        TX_IDLE,                                // Nothing held, done low
        TX_ARMED,                               // Frame frozen, header MSB on sdo
        TX_SHIFT,                               // Somewhere inside the frame
        TX_DRAINED                              // All bits presented, waiting for load
    } tx_state_e;

endpackage

//--- design/imu_sample_latch.sv
module imu_sample_latch import imu_link_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        quat_valid,             // One-cycle pulse from sensor controller
    input  imu_quat_t   quat,
    input  logic        gyro_valid,             // One-cycle pulse from sensor controller
    input  imu_vec_t    gyro,
    input  logic        ack,                    // Frame accepted by the MCU
    output imu_sample_t sample,
    output logic        pending                 // New data since last ack
);

    imu_flags_t flags_next;

    // Sticky flags: ack clears, a valid in the same cycle sets again
    always_comb begin
        flags_next = sample.flags;
        if (ack) begin
            flags_next.quat_valid = 1'b0;
            flags_next.gyro_valid = 1'b0;
        end
        if (quat_valid) begin
            flags_next.quat_valid = 1'b1;       // Valid wins over ack
        end
        if (gyro_valid) begin
            flags_next.gyro_valid = 1'b1;
        end
        flags_next.reserved = '0;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sample  <= '0;                      // Stored sample reads as zero after reset
            pending <= 1'b0;
        end else begin
            // Fields keep their last value until a fresh pulse
            if (quat_valid) begin
                sample.quat <= quat;
            end
            if (gyro_valid) begin
                sample.gyro <= gyro;
            end
            sample.flags <= flags_next;
            // Registered together with the flags so they never disagree
            pending      <= flags_next.quat_valid | flags_next.gyro_valid;
        end
    end

endmodule

//--- design/spi_port_sync.sv
`include "imu_link_macros.svh"

module spi_port_sync (
    input  logic clk,
    input  logic arst_n,
    input  logic sck,                           // From MCU, asynchronous to clk
    input  logic load,                          // From MCU, asynchronous to clk
    output logic sck_fall,                      // One clk wide
    output logic load_rise                      // One clk wide
);

    logic [`IMU_SYNC_STAGES-1:0] sck_sync;
    logic [`IMU_SYNC_STAGES-1:0] load_sync;
    logic                        sck_prev;
    logic                        load_prev;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sck_sync  <= '0;                    // Mode 0, sck idles low
            load_sync <= '0;
            sck_prev  <= 1'b0;
            load_prev <= 1'b0;
            sck_fall  <= 1'b0;
            load_rise <= 1'b0;
        end else begin
            sck_sync  <= {sck_sync[`IMU_SYNC_STAGES-2:0], sck};
            load_sync <= {load_sync[`IMU_SYNC_STAGES-2:0], load};
            sck_prev  <= sck_sync[`IMU_SYNC_STAGES-1];
            load_prev <= load_sync[`IMU_SYNC_STAGES-1];
            // Edge detect is registered, so pin edge to strobe is 3 clk
            sck_fall  <= sck_prev & ~sck_sync[`IMU_SYNC_STAGES-1];
            load_rise <= ~load_prev & load_sync[`IMU_SYNC_STAGES-1];
        end
    end

endmodule

//--- design/packet_tx.sv
`include "imu_link_macros.svh"

module packet_tx import imu_link_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  imu_sample_t sample,                 // Live latch contents
    input  logic        pending,
    input  logic        sck_fall,               // Synchronized falling sck
    input  logic        load_rise,              // Synchronized rising load
    output logic        ack,                    // To the latch, clears its flags
    output logic        done,                   // Frame held for the MCU
    output logic        sdo
);

    localparam int CNT_W = $clog2(`IMU_FRAME_BITS);

    // Counter value on the shift that presents the last bit
    localparam logic [CNT_W-1:0] LAST_SHIFT = CNT_W'(`IMU_FRAME_BITS - 2);

    tx_state_e        state;
    imu_frame_t       frame;                    // Frozen copy, doubles as shifter
    logic [CNT_W-1:0] bit_cnt;                  // Shifts done so far

    assign done = (state != TX_IDLE);
    assign ack  = load_rise & done;             // Loads with nothing held are ignored
    assign sdo  = frame[`IMU_FRAME_BITS-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= TX_IDLE;
            frame   <= '0;                      // Keeps sdo low out of reset
            bit_cnt <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (pending) begin
                        // Freeze here; later valids only touch the latch
                        frame.header <= `IMU_HEADER;
                        frame.quat   <= sample.quat;
                        frame.gyro   <= sample.gyro;
                        frame.flags  <= sample.flags;
                        bit_cnt      <= '0;
                        state        <= TX_ARMED;
                    end
                end
                TX_ARMED, TX_SHIFT: begin
                    if (ack) begin
                        state <= TX_IDLE;       // Partial read is dropped
                    end else if (sck_fall) begin
                        frame   <= imu_frame_t'({frame[`IMU_FRAME_BITS-2:0], 1'b0});
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == LAST_SHIFT) begin
                            state <= TX_DRAINED;
                        end else begin
                            state <= TX_SHIFT;
                        end
                    end
                end
                TX_DRAINED: begin
                    if (ack) begin
                        state <= TX_IDLE;
                    end else if (sck_fall) begin
                        frame <= '0;            // Line goes low after the last bit
                    end
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

endmodule

//--- design/imu_spi_link.sv
module imu_spi_link import imu_link_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    // SPI slave side, MCU is master
    input  logic      sck,
    input  logic      load,                     // Rising edge acknowledges a frame
    output logic      sdo,
    output logic      done,
    // Sensor controller side
    input  logic      quat_valid,
    input  imu_quat_t quat,
    input  logic      gyro_valid,
    input  imu_vec_t  gyro
);

    imu_sample_t sample;
    logic        pending;
    logic        sck_fall;
    logic        load_rise;
    logic        ack;

    imu_sample_latch sample_latch_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .quat_valid (quat_valid),
        .quat       (quat),
        .gyro_valid (gyro_valid),
        .gyro       (gyro),
        .ack        (ack),
        .sample     (sample),
        .pending    (pending)
    );

    // Brings the MCU lines into the clk domain
    spi_port_sync port_sync_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .sck       (sck),
        .load      (load),
        .sck_fall  (sck_fall),
        .load_rise (load_rise)
    );

    packet_tx packet_tx_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .sample    (sample),
        .pending   (pending),
        .sck_fall  (sck_fall),
        .load_rise (load_rise),
        .ack       (ack),
        .done      (done),
        .sdo       (sdo)
    );

endmodule

//--- sim/clk_gen.sv
module clk_gen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 5              // Rising edges with reset held
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;                          // Release half a period away from the edge
    end

endmodule

//--- sim/imu_spi_link_props.sv
module imu_spi_link_props (
    input logic clk,
    input logic arst_n,
    input logic sck,
    input logic load,
    input logic sdo,
    input logic done
);

    int         assert_fails = 0;               // Read by the testbench at the end
    logic       sck_q;
    logic [2:0] since_fall;                     // clk cycles since sck fell at the pin

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sck_q      <= 1'b0;
            since_fall <= 3'd7;
        end else begin
            sck_q <= sck;
            if (sck_q & ~sck) begin
                since_fall <= 3'd0;
            end else if (since_fall != 3'd7) begin
                since_fall <= since_fall + 3'd1;   // Saturates, only the window matters
            end
        end
    end

    // Transmitter sits in idle while reset is held
    a_done_in_reset: assert property (@(posedge clk) !arst_n |-> !done)
        else begin
            assert_fails++;
            $error("done high during reset");
        end

    // Acknowledge path is 3 sync stages plus the state update
    a_done_after_load: assert property (@(posedge clk) disable iff (!arst_n)
        ($rose(load) && done) |-> ##[1:5] !done)
        else begin
            assert_fails++;
            $error("done still high 5 cycles after load rose");
        end

    // Shifter only moves after an sck fall or a new frame
    a_sdo_stable: assert property (@(posedge clk) disable iff (!arst_n)
        $changed(sdo) |-> ($rose(done) || since_fall < 3'd5))
        else begin
            assert_fails++;
            $error("sdo changed outside the shift window");
        end

endmodule

bind imu_spi_link imu_spi_link_props props_i (
    .clk    (clk),
    .arst_n (arst_n),
    .sck    (sck),
    .load   (load),
    .sdo    (sdo),
    .done   (done)
);

//--- sim/imu_spi_link_tb.sv
`include "imu_link_macros.svh"

module imu_spi_link_tb import imu_link_pkg::*; ();

    localparam int HALF_SCK        = 4;             // clk cycles per sck half period
    localparam int FRAME_CYCLES    = `IMU_FRAME_BITS * 2 * HALF_SCK + 16;
    localparam int RUN_FRAMES      = 14;            // 13 full reads plus the partial one
    localparam int WATCHDOG_CYCLES = RUN_FRAMES * FRAME_CYCLES + 2000;

    logic       clk;
    logic       arst_n;
    logic       sck;
    logic       load;
    logic       quat_valid;
    imu_quat_t  quat;
    logic       gyro_valid;
    imu_vec_t   gyro;
    logic       sdo;
    logic       done;

    int         err_cnt;
    int         errs_at_start;
    int         tests_run;
    int         tests_bad;
    imu_quat_t  mdl_quat;                           // Reference copy of the latch
    imu_vec_t   mdl_gyro;
    imu_flags_t mdl_flags;
    logic       mdl_held;                           // Frame frozen, done expected high
    imu_frame_t exp_frame;

    clk_gen #(.PERIOD(40), .RST_CYCLES(5)) clk_gen_i (.clk(clk), .arst_n(arst_n));

    imu_spi_link imu_spi_link_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .sck        (sck),
        .load       (load),
        .sdo        (sdo),
        .done       (done),
        .quat_valid (quat_valid),
        .quat       (quat),
        .gyro_valid (gyro_valid),
        .gyro       (gyro)
    );

    task automatic check_frame(input string name, input imu_frame_t exp, input imu_frame_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("Error at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            err_cnt++;
            $display("Error at %0t: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (err_cnt == errs_at_start) begin
            $display("test %-14s ok", name);
        end else begin
            tests_bad++;
            $display("test %-14s %0d errors", name, err_cnt - errs_at_start);
        end
        errs_at_start = err_cnt;
    endtask

    function automatic imu_quat_t rand_quat();
        imu_quat_t q;
        q.w = 16'($urandom);
        q.x = 16'($urandom);
        q.y = 16'($urandom);
        q.z = 16'($urandom);
        return q;
    endfunction

    function automatic imu_vec_t rand_vec();
        imu_vec_t v;
        v.x = 16'($urandom);
        v.y = 16'($urandom);
        v.z = 16'($urandom);
        return v;
    endfunction

    // New value and sticky flag per pulse, frame freezes when nothing is held
    function automatic void update_model(input logic do_q, input imu_quat_t q,
                                         input logic do_g, input imu_vec_t g);
        if (do_q) begin
            mdl_quat             = q;
            mdl_flags.quat_valid = 1'b1;
        end
        if (do_g) begin
            mdl_gyro             = g;
            mdl_flags.gyro_valid = 1'b1;
        end
        if (!mdl_held && (mdl_flags.quat_valid || mdl_flags.gyro_valid)) begin
            exp_frame.header = `IMU_HEADER;
            exp_frame.quat   = mdl_quat;
            exp_frame.gyro   = mdl_gyro;
            exp_frame.flags  = mdl_flags;
            mdl_held         = 1'b1;
        end
    endfunction

    task automatic pulse_sample(input logic do_q, input imu_quat_t q,
                                input logic do_g, input imu_vec_t g);
        @(posedge clk);
        quat       <= q;
        gyro       <= g;
        quat_valid <= do_q;
        gyro_valid <= do_g;
        @(posedge clk);
        quat_valid <= 1'b0;                         // One-cycle pulse
        gyro_valid <= 1'b0;
        update_model(do_q, q, do_g, g);
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        while (done !== 1'b1 && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (done !== 1'b1) begin
            err_cnt++;
            $display("At %0t done did not rise within 10 cycles of new data", $time);
        end
    endtask

    // Mode 0 master, sdo sampled late in the high phase of sck
    task automatic read_bits(input int nbits, output imu_frame_t f);
        f = '0;
        for (int i = 0; i < nbits; i++) begin
            repeat (HALF_SCK) @(posedge clk);
            sck <= 1'b1;
            repeat (HALF_SCK - 1) @(posedge clk);
            @(negedge clk);
            f = imu_frame_t'({f[`IMU_FRAME_BITS-2:0], sdo});
            @(posedge clk);
            sck <= 1'b0;
        end
        repeat (2 * HALF_SCK) @(posedge clk);       // Last fall reaches the shifter
        if (nbits == `IMU_FRAME_BITS) begin
            @(negedge clk);
            check_bit("sdo", 1'b0, sdo);            // Line low once the frame is out
        end
    endtask

    // Load edge; the optional valids land in the cycle where ack is seen
    task automatic acknowledge(input logic do_q, input imu_quat_t q,
                               input logic do_g, input imu_vec_t g);
        @(posedge clk);
        load <= 1'b1;
        repeat (3) @(posedge clk);                  // load_rise is 3 clk behind the pin
        quat       <= q;
        gyro       <= g;
        quat_valid <= do_q;
        gyro_valid <= do_g;
        @(posedge clk);
        quat_valid <= 1'b0;
        gyro_valid <= 1'b0;
        mdl_flags = '0;                             // ack clears, same-cycle valid wins
        mdl_held  = 1'b0;
        update_model(do_q, q, do_g, g);
        @(negedge clk);
        check_bit("done", 1'b0, done);              // Low 4 clk after the load edge
        repeat (HALF_SCK) @(posedge clk);
        load <= 1'b0;
        repeat (2 * HALF_SCK) @(posedge clk);
    endtask

    task automatic reset_values();
        @(negedge clk);
        check_bit("done", 1'b0, done);
        check_bit("sdo", 1'b0, sdo);
        repeat (20) @(posedge clk);
        @(negedge clk);
        check_bit("done", 1'b0, done);              // No frame without a valid pulse
        report_test("reset");
    endtask

    task automatic quat_only();
        imu_quat_t  q;
        imu_frame_t f;
        q.w = 16'h1234;
        q.x = 16'hfffe;
        q.y = 16'h7fff;
        q.z = 16'h8000;
        pulse_sample(1'b1, q, 1'b0, '0);
        wait_done();
        read_bits(`IMU_FRAME_BITS, f);
        check_frame("frame", exp_frame, f);
        acknowledge(1'b0, '0, 1'b0, '0);
        report_test("quat_only");
    endtask

    task automatic both_kinds();
        imu_frame_t f;
        pulse_sample(1'b1, rand_quat(), 1'b1, rand_vec());
        wait_done();
        read_bits(`IMU_FRAME_BITS, f);
        check_frame("frame", exp_frame, f);
        acknowledge(1'b0, '0, 1'b0, '0);
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_bit("done", 1'b0, done);              // Nothing new, stays low
        report_test("both_kinds");
    endtask

    task automatic frozen_frame();
        imu_frame_t f;
        pulse_sample(1'b1, rand_quat(), 1'b0, '0);
        wait_done();
        pulse_sample(1'b0, '0, 1'b1, rand_vec());   // Latch only, frame already frozen
        read_bits(`IMU_FRAME_BITS, f);
        check_frame("frame", exp_frame, f);
        acknowledge(1'b0, '0, 1'b1, rand_vec());
        wait_done();                                // Back up one cycle after the drop
        read_bits(`IMU_FRAME_BITS, f);
        check_frame("frame", exp_frame, f);
        acknowledge(1'b0, '0, 1'b0, '0);
        report_test("frozen_frame");
    endtask

    task automatic aborted_read();
        imu_frame_t f;
        pulse_sample(1'b1, rand_quat(), 1'b1, rand_vec());
        wait_done();
        read_bits(40, f);
        check_frame("frame prefix", imu_frame_t'(exp_frame >> (`IMU_FRAME_BITS - 40)), f);
        acknowledge(1'b1, rand_quat(), 1'b0, '0);
        wait_done();
        read_bits(`IMU_FRAME_BITS, f);              // Restarts at the header
        check_frame("frame", exp_frame, f);
        acknowledge(1'b0, '0, 1'b0, '0);
        report_test("aborted_read");
    endtask

    task automatic random_samples();
        imu_frame_t f;
        int         kinds;
        for (int n = 0; n < 8; n++) begin
            kinds = $urandom_range(1, 3);           // Bit 0 quat, bit 1 gyro
            pulse_sample(kinds[0], rand_quat(), kinds[1], rand_vec());
            wait_done();
            read_bits(`IMU_FRAME_BITS, f);
            check_frame("frame", exp_frame, f);
            acknowledge(1'b0, '0, 1'b0, '0);
        end
        report_test("random_samples");
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

    initial begin
        sck           = 1'b0;                       // Mode 0 idle level
        load          = 1'b0;
        quat_valid    = 1'b0;
        quat          = '0;
        gyro_valid    = 1'b0;
        gyro          = '0;
        err_cnt       = 0;
        errs_at_start = 0;
        tests_run     = 0;
        tests_bad     = 0;
        mdl_quat      = '0;
        mdl_gyro      = '0;
        mdl_flags     = '0;
        mdl_held      = 1'b0;
        exp_frame     = '0;
        void'($urandom(32'h1842));
        wait (arst_n === 1'b1);
        @(posedge clk);
        reset_values();
        quat_only();
        both_kinds();
        frozen_frame();
        aborted_read();
        random_samples();
        $display("%0d tests run, %0d with errors, %0d check errors, %0d assertion failures",
                 tests_run, tests_bad, err_cnt, imu_spi_link_i.props_i.assert_fails);
        if (err_cnt == 0 && imu_spi_link_i.props_i.assert_fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- imu_spi_link.f
+incdir+include
design/imu_link_pkg.sv
design/imu_sample_latch.sv
design/spi_port_sync.sv
design/packet_tx.sv
design/imu_spi_link.sv
sim/clk_gen.sv
sim/imu_spi_link_props.sv
sim/imu_spi_link_tb.sv
